// ==== build.f ====
+incdir+logic
+incdir+tests
logic/p_hardisc.sv
logic/pipeline_id.sv
logic/rf_controller.sv
logic/pipeline_op.sv
logic/pipeline_ex.sv
logic/hardisc.sv
tests/tb_hardisc.sv

// ==== logic/hardisc.sv ====
/*
 * Top level of the reduced integer pipeline
 */
`timescale 1ns/1ps

module hardisc (
    input  logic               s_clk_i,
    input  logic               arst_n_i,
    input  logic               s_instr_valid_i,     // One-cycle instruction strobe
    input  p_hardisc::word_t   s_instr_i,
    output logic               s_wb_valid_o,        // One-cycle retire strobe
    output p_hardisc::rf_add   s_wb_rd_o,
    output p_hardisc::word_t   s_wb_val_o
);
    import p_hardisc::*;

    logic  s_idop_valid;
    logic  s_idop_useimm;
    rf_add s_idop_rs1;
    rf_add s_idop_rs2;
    rf_add s_idop_rd;
    word_t s_idop_imm;
    f_part s_idop_f;
    word_t s_idop_p1;
    word_t s_idop_p2;
    logic  s_opex_valid;
    word_t s_opex_op1;
    word_t s_opex_op2;
    rf_add s_opex_rd;
    f_part s_opex_f;
    rf_add s_ex_rd;
    word_t s_ex_res;
    logic  s_exwb_valid;
    rf_add s_exwb_rd;
    word_t s_exwb_val;

    pipeline_id m_pipe_id (
        .s_clk_i(s_clk_i), .s_instr_valid_i(s_instr_valid_i), .arst_n_i(arst_n_i),
        .s_instr_i(s_instr_i), .s_idop_valid_o(s_idop_valid), .s_idop_rs1_o(s_idop_rs1),
        .s_idop_rs2_o(s_idop_rs2), .s_idop_rd_o(s_idop_rd), .s_idop_imm_o(s_idop_imm),
        .s_idop_useimm_o(s_idop_useimm), .s_idop_f_o(s_idop_f)
    );

    rf_controller m_rfc (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i),
        .s_r_p1_add_i(s_idop_rs1), .s_r_p2_add_i(s_idop_rs2),
        .s_wb_we_i(s_exwb_valid), .s_wb_add_i(s_exwb_rd), .s_wb_val_i(s_exwb_val),
        .s_p1_val_o(s_idop_p1), .s_p2_val_o(s_idop_p2)
    );

    pipeline_op m_pipe_op (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i), .s_idop_valid_i(s_idop_valid),
        .s_idop_rs1_i(s_idop_rs1), .s_idop_rs2_i(s_idop_rs2), .s_idop_rd_i(s_idop_rd),
        .s_idop_imm_i(s_idop_imm), .s_idop_useimm_i(s_idop_useimm), .s_idop_f_i(s_idop_f),
        .s_idop_p1_i(s_idop_p1), .s_idop_p2_i(s_idop_p2),
        .s_ex_rd_i(s_ex_rd), .s_ex_res_i(s_ex_res), .s_exwb_valid_i(s_exwb_valid),
        .s_exwb_rd_i(s_exwb_rd), .s_exwb_val_i(s_exwb_val),
        .s_opex_valid_o(s_opex_valid), .s_opex_op1_o(s_opex_op1), .s_opex_op2_o(s_opex_op2),
        .s_opex_rd_o(s_opex_rd), .s_opex_f_o(s_opex_f)
    );

    pipeline_ex m_pipe_ex (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i), .s_opex_valid_i(s_opex_valid),
        .s_opex_op1_i(s_opex_op1), .s_opex_op2_i(s_opex_op2), .s_opex_rd_i(s_opex_rd),
        .s_opex_f_i(s_opex_f), .s_ex_rd_o(s_ex_rd), .s_ex_res_o(s_ex_res),
        .s_exwb_valid_o(s_exwb_valid), .s_exwb_rd_o(s_exwb_rd), .s_exwb_val_o(s_exwb_val)
    );

    assign s_wb_valid_o = s_exwb_valid;     // Writeback port mirrors exwb
    assign s_wb_rd_o    = s_exwb_rd;
    assign s_wb_val_o   = s_exwb_val;

endmodule

// ==== logic/p_hardisc.sv ====
/*
 * Shared types of the reduced pipeline: data word, register address
 * and the ALU function encoding
 */
package p_hardisc;

    typedef logic [31:0] word_t;    // Data word
    typedef logic [4:0] rf_add;     // Register file address

    // ALU function carried from decode down to execute
    typedef enum logic [3:0] {
        F_ADD,
        F_SUB,
        F_SLL,
        F_SLT,
        F_SLTU,
        F_XOR,
        F_SRL,
        F_SRA,
        F_OR,
        F_AND,
        F_LUI
    } f_part;

endpackage

// ==== logic/pipeline_ex.sv ====
/*
 * Execute stage: ALU, execute forward path and the writeback register
 */
`timescale 1ns/1ps

module pipeline_ex (
    input  logic               s_clk_i,
    input  logic               arst_n_i,
    input  logic               s_opex_valid_i,
    input  p_hardisc::word_t   s_opex_op1_i,
    input  p_hardisc::word_t   s_opex_op2_i,
    input  p_hardisc::rf_add   s_opex_rd_i,
    input  p_hardisc::f_part   s_opex_f_i,
    output p_hardisc::rf_add   s_ex_rd_o,       // x0 when the stage is empty
    output p_hardisc::word_t   s_ex_res_o,
    output logic               s_exwb_valid_o,
    output p_hardisc::rf_add   s_exwb_rd_o,
    output p_hardisc::word_t   s_exwb_val_o
);
    import p_hardisc::*;

    word_t      s_alu;
    word_t      s_res;
    logic [4:0] s_shamt;

    assign s_shamt = s_opex_op2_i[4:0];

    always_comb begin
        case (s_opex_f_i)
            F_ADD:   s_alu = s_opex_op1_i + s_opex_op2_i;
            F_SUB:   s_alu = s_opex_op1_i - s_opex_op2_i;
            F_SLL:   s_alu = s_opex_op1_i << s_shamt;
            F_SLT:   s_alu = {31'b0, $signed(s_opex_op1_i) < $signed(s_opex_op2_i)};
            F_SLTU:  s_alu = {31'b0, s_opex_op1_i < s_opex_op2_i};
            F_XOR:   s_alu = s_opex_op1_i ^ s_opex_op2_i;
            F_SRL:   s_alu = s_opex_op1_i >> s_shamt;
            F_SRA:   s_alu = word_t'($signed(s_opex_op1_i) >>> s_shamt);
            F_OR:    s_alu = s_opex_op1_i | s_opex_op2_i;
            F_AND:   s_alu = s_opex_op1_i & s_opex_op2_i;
            F_LUI:   s_alu = s_opex_op2_i;          // Upper immediate passes through
            default: s_alu = '0;
        endcase
    end

    // Results for x0 are zero so every path matches the register file
    assign s_res      = (s_opex_rd_i == '0) ? '0 : s_alu;
    assign s_ex_rd_o  = s_opex_valid_i ? s_opex_rd_i : '0;
    assign s_ex_res_o = s_res;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_exwb_valid_o <= 1'b0;
            s_exwb_rd_o    <= '0;
        end else begin
            s_exwb_valid_o <= s_opex_valid_i;
            s_exwb_rd_o    <= s_opex_rd_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        s_exwb_val_o <= s_res;
    end

endmodule

// ==== logic/pipeline_id.sv ====
/*
 * Decode stage: splits an instruction into register addresses, immediate
 * and ALU function, and registers them towards the operand stage
 */
`timescale 1ns/1ps
`include "settings_cfg.svh"

module pipeline_id (
    input  logic               s_clk_i,
    input  logic               arst_n_i,
    input  logic               s_instr_valid_i,     // Instruction strobe
    input  p_hardisc::word_t   s_instr_i,
    output logic               s_idop_valid_o,
    output p_hardisc::rf_add   s_idop_rs1_o,
    output p_hardisc::rf_add   s_idop_rs2_o,
    output p_hardisc::rf_add   s_idop_rd_o,
    output p_hardisc::word_t   s_idop_imm_o,
    output logic               s_idop_useimm_o,     // Operand 2 comes from the immediate
    output p_hardisc::f_part   s_idop_f_o
);
    import p_hardisc::*;

    logic [6:0] s_opc;
    logic [2:0] s_f3;
    logic [6:0] s_f7;
    logic       s_alt;
    logic       s_legal;
    logic       s_useimm;
    rf_add      s_rs1;
    word_t      s_imm;
    f_part      s_f;

    assign s_opc = s_instr_i[6:0];
    assign s_f3  = s_instr_i[14:12];
    assign s_f7  = s_instr_i[31:25];
    assign s_alt = (s_f7 == `F7_ALT);

    always_comb begin
        s_legal  = 1'b0;
        s_useimm = 1'b0;
        s_rs1    = s_instr_i[19:15];
        s_imm    = {{20{s_instr_i[31]}}, s_instr_i[31:20]};    // I-type, sign extended
        case (s_f3)
            `F3_ADD:  s_f = (s_alt && s_opc == `OPC_OP) ? F_SUB : F_ADD;
            `F3_SLL:  s_f = F_SLL;
            `F3_SLT:  s_f = F_SLT;
            `F3_SLTU: s_f = F_SLTU;
            `F3_XOR:  s_f = F_XOR;
            `F3_SR:   s_f = s_alt ? F_SRA : F_SRL;
            `F3_OR:   s_f = F_OR;
            default:  s_f = F_AND;
        endcase
        case (s_opc)
            `OPC_OP: begin
                s_legal = (s_f7 == 7'b0) || (s_alt && (s_f3 == `F3_ADD || s_f3 == `F3_SR));
            end
            `OPC_OPIMM: begin
                s_useimm = 1'b1;
                s_legal  = 1'b1;
                if (s_f3 == `F3_SLL || s_f3 == `F3_SR) begin
                    s_imm   = {27'b0, s_instr_i[24:20]};           // Shift amount
                    s_legal = (s_f7 == 7'b0) || (s_alt && s_f3 == `F3_SR);
                end
            end
            `OPC_LUI: begin
                s_legal  = 1'b1;
                s_useimm = 1'b1;
                s_rs1    = '0;
                s_imm    = {s_instr_i[31:12], 12'b0};              // U-type
                s_f      = F_LUI;
            end
            default: s_legal = 1'b0;
        endcase
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_idop_valid_o  <= 1'b0;
            s_idop_rs1_o    <= '0;
            s_idop_rs2_o    <= '0;
            s_idop_rd_o     <= '0;
            s_idop_useimm_o <= 1'b0;
            s_idop_f_o      <= F_ADD;
        end else begin
            s_idop_valid_o  <= s_instr_valid_i && s_legal;     // Illegal encodings are dropped
            s_idop_rs1_o    <= s_rs1;
            s_idop_rs2_o    <= s_instr_i[24:20];
            s_idop_rd_o     <= s_instr_i[11:7];
            s_idop_useimm_o <= s_useimm;
            s_idop_f_o      <= s_f;
        end
    end

    always_ff @(posedge s_clk_i) begin
        s_idop_imm_o <= s_imm;
    end

endmodule

// ==== logic/pipeline_op.sv ====
/*
 * Operand stage: resolves source registers against the forward paths,
 * applies the immediate and registers the operand pair
 */
`timescale 1ns/1ps

module pipeline_op (
    input  logic               s_clk_i,
    input  logic               arst_n_i,
    input  logic               s_idop_valid_i,
    input  p_hardisc::rf_add   s_idop_rs1_i,
    input  p_hardisc::rf_add   s_idop_rs2_i,
    input  p_hardisc::rf_add   s_idop_rd_i,
    input  p_hardisc::word_t   s_idop_imm_i,
    input  logic               s_idop_useimm_i,
    input  p_hardisc::f_part   s_idop_f_i,
    input  p_hardisc::word_t   s_idop_p1_i,     // Register file read values
    input  p_hardisc::word_t   s_idop_p2_i,
    input  p_hardisc::rf_add   s_ex_rd_i,       // Execute forward path
    input  p_hardisc::word_t   s_ex_res_i,
    input  logic               s_exwb_valid_i,  // Writeback forward path
    input  p_hardisc::rf_add   s_exwb_rd_i,
    input  p_hardisc::word_t   s_exwb_val_i,
    output logic               s_opex_valid_o,
    output p_hardisc::word_t   s_opex_op1_o,
    output p_hardisc::word_t   s_opex_op2_o,
    output p_hardisc::rf_add   s_opex_rd_o,
    output p_hardisc::f_part   s_opex_f_o
);
    import p_hardisc::*;

    word_t s_op1;
    word_t s_op2;

    // Youngest producer wins, x0 is never forwarded
    function automatic word_t fwd_sel(input rf_add rs, input word_t rf_val, input rf_add ex_rd,
                                      input word_t ex_res, input logic wb_valid,
                                      input rf_add wb_rd, input word_t wb_val);
        if (rs != '0 && rs == ex_rd)
            return ex_res;
        if (wb_valid && rs != '0 && rs == wb_rd)
            return wb_val;
        return rf_val;
    endfunction

    assign s_op1 = fwd_sel(s_idop_rs1_i, s_idop_p1_i, s_ex_rd_i, s_ex_res_i,
                           s_exwb_valid_i, s_exwb_rd_i, s_exwb_val_i);
    assign s_op2 = s_idop_useimm_i ? s_idop_imm_i :
                   fwd_sel(s_idop_rs2_i, s_idop_p2_i, s_ex_rd_i, s_ex_res_i,
                           s_exwb_valid_i, s_exwb_rd_i, s_exwb_val_i);

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_opex_valid_o <= 1'b0;
            s_opex_rd_o    <= '0;
            s_opex_f_o     <= F_ADD;
        end else begin
            s_opex_valid_o <= s_idop_valid_i;
            s_opex_rd_o    <= s_idop_rd_i;
            s_opex_f_o     <= s_idop_f_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        s_opex_op1_o <= s_op1;
        s_opex_op2_o <= s_op2;
    end

endmodule

// ==== logic/rf_controller.sv ====
/*
 * Register file with two combinational read ports and one write port
 */
`timescale 1ns/1ps
`include "settings_cfg.svh"

module rf_controller (
    input  logic               s_clk_i,
    input  logic               arst_n_i,
    input  p_hardisc::rf_add   s_r_p1_add_i,
    input  p_hardisc::rf_add   s_r_p2_add_i,
    input  logic               s_wb_we_i,       // Write strobe from exwb
    input  p_hardisc::rf_add   s_wb_add_i,
    input  p_hardisc::word_t   s_wb_val_i,
    output p_hardisc::word_t   s_p1_val_o,
    output p_hardisc::word_t   s_p2_val_o
);
    import p_hardisc::*;

    word_t s_regs [1:`RF_REGS-1];               // x0 has no storage

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `RF_REGS; i++) begin
                s_regs[i] <= '0;
            end
        end else if (s_wb_we_i && s_wb_add_i != '0) begin
            s_regs[s_wb_add_i] <= s_wb_val_i;
        end
    end

    // Address 0 always reads as zero
    assign s_p1_val_o = (s_r_p1_add_i == '0) ? '0 : s_regs[s_r_p1_add_i];
    assign s_p2_val_o = (s_r_p2_add_i == '0) ? '0 : s_regs[s_r_p2_add_i];

endmodule

// ==== logic/settings_cfg.svh ====
/*
 * Opcode, funct3 and funct7 encodings of the supported instructions
 * and the register file size
 */
`ifndef SETTINGS_CFG_SVH
`define SETTINGS_CFG_SVH

`define OPC_OP      7'b0110011      // Register-register ALU
`define OPC_OPIMM   7'b0010011      // Register-immediate ALU
`define OPC_LUI     7'b0110111      // Load upper immediate

`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101          // SRL or SRA, picked by funct7
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F7_ALT      7'b0100000      // Selects SUB or SRA

`define RF_REGS     32

`endif

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run, the pass line on stdout decides the status
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f build.f --top-module tb_hardisc \
    && ./obj_dir/Vtb_hardisc | tee /dev/stderr | grep -qx "Simulation passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

// ==== tests/tb_model.svh ====
/*
 * Reference model: architectural register array and the expected
 * result of one instruction executed in program order
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] ref_regs [0:`RF_REGS-1];       // Register state in program order

// Returns legal, with the destination and the value the instruction writes
function automatic logic ref_result(input logic [31:0] word, output logic [4:0] rd,
                                    output logic [31:0] val);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sra;
    logic        alt;
    logic        ok;
    opc = word[6:0];
    f3  = word[14:12];
    rd  = word[11:7];
    a   = ref_regs[word[19:15]];
    b   = (opc == `OPC_OP) ? ref_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
    sra = $signed(a) >>> b[4:0];
    // The alternate funct7 only means SUB or SRA
    alt = (word[31:25] == `F7_ALT) && (f3 == `F3_SR || (f3 == `F3_ADD && opc == `OPC_OP));
    ok  = (word[31:25] == 7'b0) || alt;
    if (opc == `OPC_OPIMM && f3 != `F3_SLL && f3 != `F3_SR)
        ok = 1'b1;                          // Upper bits are immediate here
    case (f3)
        `F3_ADD:  val = alt ? a - b : a + b;
        `F3_SLL:  val = a << b[4:0];
        `F3_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `F3_SLTU: val = (a < b) ? 32'd1 : 32'd0;
        `F3_XOR:  val = a ^ b;
        `F3_SR:   val = alt ? sra : a >> b[4:0];
        `F3_OR:   val = a | b;
        default:  val = a & b;
    endcase
    if (opc == `OPC_LUI) begin
        val = {word[31:12], 12'b0};
        ok  = 1'b1;
    end else if (opc != `OPC_OP && opc != `OPC_OPIMM) begin
        ok = 1'b0;
    end
    if (rd == 5'd0)
        val = '0;                           // x0 never holds a value
    return ok;
endfunction

`endif

// ==== tests/tb_hardisc.sv ====
/*
 * Testbench of the reduced pipeline: reference model, directed and
 * random instruction streams, compare process and watchdog
 */
`timescale 1ns/1ps
`include "settings_cfg.svh"

module tb_hardisc;
    localparam int CLK_PERIOD = 40;
    localparam int ITERS      = 8;          // Operand sets per function and per distance
    localparam int STREAM_LEN = 60;
    localparam int MAX_GAP    = 3;
    // Upper bound of stimulus slots over all tests, drains included
    localparam int SLOTS = 37 + ITERS * (10 * 5 + 9 * 3 + 1 + 4 * 7) + 8 + 12
                         + STREAM_LEN * (MAX_GAP + 2) + 6 * 8;
    localparam logic [29:0] R_F3 = {`F3_AND, `F3_OR, `F3_SR, `F3_SR, `F3_XOR, `F3_SLTU,
                                    `F3_SLT, `F3_SLL, `F3_ADD, `F3_ADD};
    localparam logic [26:0] I_F3 = {`F3_SR, `F3_SR, `F3_SLL, `F3_AND, `F3_OR, `F3_XOR,
                                    `F3_SLTU, `F3_SLT, `F3_ADD};

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_val;
    int          cyc = 0;
    int          err_count;
    int          chk_count;
    int          err_mark;
    logic [4:0]  exp_rd_q [$];              // Expected retirements in program order
    logic [31:0] exp_val_q [$];
    int          exp_cyc_q [$];

    `include "tb_model.svh"

    hardisc dut0 (
        .s_clk_i(clk), .arst_n_i(arst_n), .s_instr_valid_i(instr_valid), .s_instr_i(instr),
        .s_wb_valid_o(wb_valid), .s_wb_rd_o(wb_rd), .s_wb_val_o(wb_val)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #((SLOTS + 50) * CLK_PERIOD);
        $display("Watchdog expired with %0d retirements outstanding", exp_rd_q.size());
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_count++;
        if (got !== exp) begin
            err_count++;
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin : compare
        int due;
        if (arst_n && wb_valid !== 1'b0) begin
            if (exp_rd_q.size() == 0) begin
                err_count++;
                $display("Retire of x%0d at cycle %0d with no instruction outstanding",
                         wb_rd, cyc);
            end else begin
                due = exp_cyc_q.pop_front();
                check_value("s_wb_rd_o", {27'b0, wb_rd}, {27'b0, exp_rd_q.pop_front()});
                check_value("s_wb_val_o", wb_val, exp_val_q.pop_front());
                if (cyc != due) begin
                    err_count++;
                    $display("Retire came at cycle %0d instead of cycle %0d", cyc, due);
                end
            end
        end
    end

    // Drives one strobe and records what the reference expects from it
    task automatic send(input logic [31:0] word);
        logic [4:0]  rd;
        logic [31:0] val;
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr       = word;
        if (ref_result(word, rd, val)) begin
            ref_regs[rd] = val;
            exp_rd_q.push_back(rd);
            exp_val_q.push_back(val);
            exp_cyc_q.push_back(cyc + 3);   // Third cycle after the strobe
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            instr_valid = 1'b0;
            instr       = $urandom;         // Ignored without the strobe
        end
    endtask

    task automatic end_test(input string name);
        idle(1);
        while (exp_rd_q.size() != 0)
            @(posedge clk);
        idle(2);
        $display("test %s finished with %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    // Index 0 to 9 is ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    function automatic logic [31:0] r_instr(input int k, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        return {((k == 1 || k == 7) ? `F7_ALT : 7'b0), rs2, rs1, R_F3[3*k +: 3], rd, `OPC_OP};
    endfunction

    // Index 0 to 5 is ADDI to ANDI, 6 to 8 the shifts by rnd[4:0]
    function automatic logic [31:0] i_instr(input int k, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [31:0] rnd);
        logic [11:0] imm;
        imm = (k < 6) ? rnd[11:0] : {((k == 8) ? `F7_ALT : 7'b0), rnd[4:0]};
        return {imm, rs1, I_F3[3*k +: 3], rd, `OPC_OPIMM};
    endfunction

    function automatic logic [31:0] legal_instr();
        logic [4:0] rd;
        logic [4:0] rs1;
        rd  = 5'($urandom_range(0, 7));     // Few registers, many hazards
        rs1 = 5'($urandom_range(0, 7));
        case ($urandom_range(0, 2))
            0:       return r_instr($urandom_range(0, 9), rd, rs1, 5'($urandom_range(0, 7)));
            1:       return i_instr($urandom_range(0, 8), rd, rs1, $urandom);
            default: return {20'($urandom), rd, `OPC_LUI};
        endcase
    endfunction

    function automatic logic [31:0] bad_encoding();
        case ($urandom_range(0, 2))
            0:       return {25'($urandom), 7'b0000011};             // Load
            1:       return {7'b0000001, 18'($urandom), `OPC_OP};    // M extension
            default: return {`F7_ALT, 10'($urandom), `F3_SLL, 5'($urandom), `OPC_OPIMM};
        endcase
    endfunction

    // LUI and ADDI pair, upper part rounded for the sign of the low part
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
        send({val[31:12] + {19'b0, val[11]}, rd, `OPC_LUI});
        send(i_instr(0, rd, rd, val));
    endtask

    initial begin
        void'($urandom(32'h8a3cce94));
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        err_count   = 0;
        chk_count   = 0;
        err_mark    = 0;
        for (int i = 0; i < `RF_REGS; i++)
            ref_regs[i] = '0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Quiet pipeline after reset, then every register reads zero
        idle(5);
        for (int r = 0; r < 32; r++)
            send(r_instr(0, (r == 0) ? 5'd1 : 5'(r), 5'(r), 5'd0));
        end_test("reset");

        // Sign corner cases in the first two operand sets
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < ITERS; i++) begin
                load_reg(5'd1, (i == 0) ? 32'h8000_0000 : (i == 1) ? 32'd1 : $urandom);
                load_reg(5'd2, (i == 0) ? 32'd1 : (i == 1) ? 32'hffff_ffff : $urandom);
                send(r_instr(k, 5'd3, 5'd1, 5'd2));
            end
        end
        for (int k = 0; k < 9; k++) begin
            for (int i = 0; i < ITERS; i++) begin
                load_reg(5'd1, (i == 0) ? 32'h8000_0000 : $urandom);
                send(i_instr(k, 5'd4, 5'd1, (i == 1) ? 32'hffff_ffff : $urandom));
            end
        end
        for (int i = 0; i < ITERS; i++)
            send({20'($urandom), 5'd5, `OPC_LUI});
        end_test("alu");

        // Consumer at distance 1 to 4 from its producer, on either source port
        for (int d = 1; d <= 4; d++) begin
            for (int i = 0; i < ITERS; i++) begin
                load_reg(5'd5, $urandom);
                send(r_instr($urandom_range(0, 9), 5'd6, 5'd5, 5'd5));
                repeat (d - 1)
                    send(r_instr(5, 5'd20, 5'd21, 5'd22));
                if (i % 2 == 1)
                    send(r_instr($urandom_range(0, 9), 5'd7, 5'd6, 5'd5));
                else
                    send(r_instr($urandom_range(0, 9), 5'd7, 5'd5, 5'd6));
            end
        end
        repeat (8)
            send(i_instr(0, 5'd9, 5'd9, 32'd3));
        end_test("forward");

        send(i_instr(0, 5'd0, 5'd1, 32'd123));
        send({20'habcde, 5'd0, `OPC_LUI});
        send(r_instr(8, 5'd10, 5'd0, 5'd0));
        send(r_instr(0, 5'd11, 5'd0, 5'd1));
        idle(2);
        send(i_instr(3, 5'd12, 5'd0, 32'h7ff));
        end_test("x0");

        for (int i = 0; i < STREAM_LEN; i++)
            send(($urandom_range(0, 3) == 0) ? bad_encoding() : legal_instr());
        end_test("illegal");

        for (int i = 0; i < STREAM_LEN; i++) begin
            send(legal_instr());
            idle($urandom_range(0, MAX_GAP));
        end
        end_test("gaps");

        $display("checks %0d, errors %0d", chk_count, err_count);
        if (err_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
